//--- taylor_settings.svh
`ifndef TAYLOR_SETTINGS_SVH
`define TAYLOR_SETTINGS_SVH

// Number of polynomial cores.
`define NUM_CORES 4

`define ORDER 4 // Coefficients c0 to c3.

`define FRAC_BITS 15 // Fraction bits of every fixed-point value.

`define IN_CREDITS 4 // Input FIFO depth.

`define OUT_CREDITS 2 // Initial credits toward the consumer.

`define STAGGER_CYCLES 8 // Cycles between core releases.

`endif

//--- taylor_num_pkg.sv
`include "taylor_settings.svh"

package taylor_num_pkg;

	// Input argument x.
	typedef logic signed [18:0] sample_t; // Q3.15.

	typedef logic signed [18:0] coef_t; // Q3.15.

	// Horner accumulator and result.
	typedef logic signed [27:0] acc_t; // Q12.15.

	typedef coef_t [`ORDER-1:0] coef_bank_t; // Index k holds ck.

endpackage

//--- taylor_bus_pkg.sv
`include "taylor_settings.svh"

package taylor_bus_pkg;

	typedef logic [7:0] tag_t;

	typedef logic [$clog2(`NUM_CORES)-1:0] core_id_t;

	typedef enum logic {
		OP_SAMPLE = 1'b0,
		OP_COEF   = 1'b1
	} cmd_op_e;

	typedef struct packed {
		cmd_op_e                 op;
		logic [3:0]              rsvd;
		tag_t                    tag;
		taylor_num_pkg::sample_t sample;
	} sample_view_t;

	typedef struct packed {
		cmd_op_e               op;
		logic [9:0]            rsvd;
		logic [1:0]            idx;
		taylor_num_pkg::coef_t value;
	} coef_view_t;

	// Input word decoded by its top bit.
	typedef union packed {
		sample_view_t smp;
		coef_view_t   coef;
	} cmd_word_u;

endpackage

//--- taylor_core_if.sv
interface core_req_if;
	import taylor_num_pkg::*;
	import taylor_bus_pkg::*;

	logic    valid;
	sample_t sample;
	tag_t    tag;
	logic    ready;

	modport source (
		output valid,
		output sample,
		output tag,
		input  ready
	);

	modport sink (
		input  valid,
		input  sample,
		input  tag,
		output ready
	);
endinterface

interface core_res_if;
	import taylor_num_pkg::*;
	import taylor_bus_pkg::*;

	logic valid; // Held until grant.
	acc_t acc;
	tag_t tag;
	logic grant;

	modport source (
		output valid,
		output acc,
		output tag,
		input  grant
	);

	modport sink (
		input  valid,
		input  acc,
		input  tag,
		output grant
	);
endinterface

//--- reset_stagger.sv
`include "taylor_settings.svh"

module reset_stagger (
	input  logic                  clk,
	input  logic                  arst_n,
	output logic [`NUM_CORES-1:0] core_rst_n
);
	localparam int CNT_W = (`STAGGER_CYCLES > 1) ? $clog2(`STAGGER_CYCLES) : 1;
	localparam int IDX_W = $clog2(`NUM_CORES + 1);

	logic [CNT_W-1:0] cnt;
	logic [IDX_W-1:0] rel_idx; // Next core to release.
	logic             running;

	assign running = (rel_idx < IDX_W'(`NUM_CORES));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt        <= '0;
			rel_idx    <= '0;
			core_rst_n <= '0;
		end else if (running) begin
			if (cnt == CNT_W'(`STAGGER_CYCLES - 1)) begin
				cnt        <= '0;
				rel_idx    <= rel_idx + 1'b1;
				core_rst_n <= core_rst_n | (`NUM_CORES'(1) << rel_idx);
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// A released core stays released.
	a_no_reenter: assert property (@(posedge clk) disable iff (!arst_n)
		($past(core_rst_n) & ~core_rst_n) == '0);

endmodule

//--- sample_dispatcher.sv
`include "taylor_settings.svh"

module sample_dispatcher (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       in_valid,
	input  logic [31:0]                in_word,
	output logic                       in_credit,
	output taylor_num_pkg::coef_bank_t coef_bank,
	core_req_if.source                 req [`NUM_CORES]
);
	import taylor_bus_pkg::*;

	localparam int DEPTH = `IN_CREDITS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	cmd_word_u             fifo_mem [DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [CNT_W-1:0]      count;
	cmd_word_u             head;
	logic                  head_valid;
	logic                  head_is_coef;
	logic [`NUM_CORES-1:0] ready_vec;
	logic [`NUM_CORES-1:0] pick;
	logic [`NUM_CORES-1:0] pending; // Core holds a sample not yet returned.
	logic                  all_idle;
	logic                  issue;
	logic                  pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign head         = fifo_mem[rd_ptr];
	assign head_valid   = (count != '0);
	assign head_is_coef = (head.coef.op == OP_COEF);
	assign pick         = ready_vec & (~ready_vec + 1'b1); // Lowest ready core.
	assign all_idle     = ((pending & ~ready_vec) == '0);
	assign issue        = head_valid && !head_is_coef && (ready_vec != '0);
	assign pop          = issue || (head_valid && head_is_coef && all_idle);
	assign in_credit    = pop;

	for (genvar k = 0; k < `NUM_CORES; k++) begin : g_req
		assign ready_vec[k]  = req[k].ready;
		assign req[k].valid  = head_valid && !head_is_coef && pick[k];
		assign req[k].sample = head.smp.sample;
		assign req[k].tag    = head.smp.tag;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			fifo_mem[wr_ptr] <= in_word;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			pending <= '0;
		end else begin
			if (in_valid) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count + CNT_W'(in_valid) - CNT_W'(pop);
			for (int k = 0; k < `NUM_CORES; k++) begin
				if (issue && pick[k]) begin
					pending[k] <= 1'b1;
				end else if (ready_vec[k]) begin
					pending[k] <= 1'b0;
				end
			end
		end
	end

	// Coefficients change only between evaluations.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			coef_bank <= '0;
		end else if (pop && head_is_coef) begin
			coef_bank[head.coef.idx] <= head.coef.value;
		end
	end

	// Producer must hold a credit for every word.
	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		in_valid |-> count < CNT_W'(DEPTH));

endmodule

//--- horner_core.sv
`include "taylor_settings.svh"

module horner_core (
	input  logic                       clk,
	input  logic                       core_rst_n,
	input  taylor_num_pkg::coef_bank_t coef_bank,
	core_req_if.sink                   req,
	core_res_if.source                 res
);
	import taylor_num_pkg::*;
	import taylor_bus_pkg::*;

	localparam int IDX_W = $clog2(`ORDER);
	localparam int LAT   = `ORDER;

	typedef enum logic [1:0] {
		S_OFF,
		S_IDLE,
		S_BUSY,
		S_DONE
	} state_e;

	state_e                                         state;
	logic [IDX_W-1:0]                               idx;
	sample_t                                        x_q;
	acc_t                                           acc_q;
	tag_t                                           tag_q;
	logic signed [$bits(acc_t)+$bits(sample_t)-1:0] prod;
	acc_t                                           acc_nxt;
	logic                                           fire;

	assign fire      = req.valid && req.ready;
	assign req.ready = (state == S_IDLE);
	assign prod      = acc_q * x_q;
	assign acc_nxt   = acc_t'(prod >>> `FRAC_BITS) + acc_t'(coef_bank[idx]);

	always_ff @(posedge clk or negedge core_rst_n) begin
		if (!core_rst_n) begin
			state <= S_OFF;
			idx   <= '0;
		end else begin
			case (state)
				S_OFF: state <= S_IDLE;
				S_IDLE: begin
					if (fire) begin
						state <= S_BUSY;
						idx   <= IDX_W'(`ORDER - 2);
					end
				end
				S_BUSY: begin
					idx <= idx - 1'b1;
					if (idx == '0) begin
						state <= S_DONE;
					end
				end
				S_DONE: begin
					if (res.grant) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_OFF;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			x_q   <= req.sample;
			tag_q <= req.tag;
			acc_q <= acc_t'(coef_bank[`ORDER-1]); // Start from top coefficient.
		end else if (state == S_BUSY) begin
			acc_q <= acc_nxt;
		end
	end

	assign res.valid = (state == S_DONE);
	assign res.acc   = acc_q;
	assign res.tag   = tag_q;

	a_offer_idle: assert property (@(posedge clk) disable iff (!core_rst_n)
		req.valid |-> state == S_IDLE);

	a_latency: assert property (@(posedge clk) disable iff (!core_rst_n)
		$rose(res.valid) |-> $past(fire, LAT));

endmodule

//--- result_arbiter.sv
`include "taylor_settings.svh"

module result_arbiter (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     out_credit,
	core_res_if.sink                 res [`NUM_CORES],
	output logic                     out_valid,
	output taylor_num_pkg::acc_t     out_data,
	output taylor_bus_pkg::tag_t     out_tag,
	output taylor_bus_pkg::core_id_t out_core
);
	import taylor_num_pkg::*;
	import taylor_bus_pkg::*;

	localparam int CRD_W = $clog2(`OUT_CREDITS + 1);

	logic [`NUM_CORES-1:0] req_vec;
	acc_t                  acc_vec [`NUM_CORES];
	tag_t                  tag_vec [`NUM_CORES];
	logic [CRD_W-1:0]      credits;
	core_id_t              last_q; // Last core granted.
	core_id_t              gnt_idx;
	logic                  gnt_any;

	for (genvar k = 0; k < `NUM_CORES; k++) begin : g_res
		assign req_vec[k]   = res[k].valid;
		assign acc_vec[k]   = res[k].acc;
		assign tag_vec[k]   = res[k].tag;
		assign res[k].grant = gnt_any && (gnt_idx == core_id_t'(k));
	end

	// Search starts one past the last grant.
	always_comb begin
		int cand;
		gnt_any = 1'b0;
		gnt_idx = last_q;
		for (int i = 1; i <= `NUM_CORES; i++) begin
			cand = (int'(last_q) + i) % `NUM_CORES;
			if (!gnt_any && req_vec[cand] && credits != '0) begin
				gnt_any = 1'b1;
				gnt_idx = core_id_t'(cand);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits   <= CRD_W'(`OUT_CREDITS);
			last_q    <= core_id_t'(`NUM_CORES - 1); // Core 0 first.
			out_valid <= 1'b0;
		end else begin
			credits   <= credits + CRD_W'(out_credit) - CRD_W'(gnt_any);
			out_valid <= gnt_any;
			if (gnt_any) begin
				last_q <= gnt_idx;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (gnt_any) begin
			out_data <= acc_vec[gnt_idx];
			out_tag  <= tag_vec[gnt_idx];
			out_core <= gnt_idx;
		end
	end

	a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
		credits <= CRD_W'(`OUT_CREDITS));

	a_credit_used: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> $past(credits) != '0);

endmodule

//--- taylor_multicore.sv
`include "taylor_settings.svh"

module taylor_multicore (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	input  logic [31:0]              in_word,
	output logic                     in_credit,
	output logic                     out_valid,
	output taylor_num_pkg::acc_t     out_data,
	output taylor_bus_pkg::tag_t     out_tag,
	output taylor_bus_pkg::core_id_t out_core,
	input  logic                     out_credit
);
	import taylor_num_pkg::*;

	logic [`NUM_CORES-1:0] core_rst_n;
	coef_bank_t            coef_bank; // Shared by all cores.

	core_req_if req_if [`NUM_CORES] ();
	core_res_if res_if [`NUM_CORES] ();

	reset_stagger u_rst (
		.clk        (clk),
		.arst_n     (arst_n),
		.core_rst_n (core_rst_n)
	);

	sample_dispatcher u_disp (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_word   (in_word),
		.in_credit (in_credit),
		.coef_bank (coef_bank),
		.req       (req_if)
	);

	for (genvar k = 0; k < `NUM_CORES; k++) begin : g_core
		horner_core u_core (
			.clk        (clk),
			.core_rst_n (core_rst_n[k]),
			.coef_bank  (coef_bank),
			.req        (req_if[k]),
			.res        (res_if[k])
		);
	end

	result_arbiter u_arb (
		.clk        (clk),
		.arst_n     (arst_n),
		.out_credit (out_credit),
		.res        (res_if),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_tag    (out_tag),
		.out_core   (out_core)
	);

endmodule

//--- tb_taylor_multicore.sv
`include "taylor_settings.svh"

module tb_taylor_multicore;
	timeunit 1ns;
	timeprecision 100ps;

	import taylor_num_pkg::*;
	import taylor_bus_pkg::*;

	typedef enum logic [2:0] {
		K_COEF,
		K_SAMPLE,
		K_RAND,
		K_SETTLE,
		K_HOLD,
		K_END_HOLD,
		K_DRAIN
	} kind_e;

	typedef struct packed {
		kind_e       kind;
		logic [31:0] value;
		logic [7:0]  tag; // Coefficient index for K_COEF.
	} entry_t;

	localparam int N_STIM  = 30;
	localparam int TIMEOUT = 500;

	logic        clk;
	logic        arst_n;
	logic        in_valid;
	logic [31:0] in_word;
	logic        in_credit;
	logic        out_valid;
	acc_t        out_data;
	tag_t        out_tag;
	core_id_t    out_core;
	logic        out_credit;

	logic [31:0]           rng;
	logic signed [18:0]    coef_m [`ORDER];
	acc_t                  exp_data [256];
	logic [255:0]          exp_live; // Tags still in flight.
	int                    outstanding;
	int                    sent;
	int                    credit_seen;
	int                    avail; // Input credits held by the producer.
	logic                  credit_late;
	int                    owed; // Output credits still to return.
	int                    ret_wait;
	logic                  hold;
	int                    cycle;
	int                    results;
	int                    hold_results;
	logic [`NUM_CORES-1:0] core_mask;

	// Exponential series first, then a reload with the sine series.
	entry_t stim [N_STIM] = '{
		'{K_SETTLE, 32'(`STAGGER_CYCLES + 2), 8'h00},
		'{K_COEF, 32'h00008000, 8'h00},
		'{K_COEF, 32'h00008000, 8'h01},
		'{K_COEF, 32'h00004000, 8'h02},
		'{K_COEF, 32'h00001555, 8'h03},
		'{K_SAMPLE, 32'h00004000, 8'h01},
		'{K_DRAIN, 32'd0, 8'h00},
		'{K_SETTLE, 32'(`NUM_CORES * `STAGGER_CYCLES + 2), 8'h00},
		'{K_RAND, 32'd0, 8'h02},
		'{K_RAND, 32'd0, 8'h03},
		'{K_RAND, 32'd0, 8'h04},
		'{K_RAND, 32'd0, 8'h05},
		'{K_DRAIN, 32'd2, 8'h00},
		'{K_HOLD, 32'd0, 8'h00},
		'{K_RAND, 32'd0, 8'h06},
		'{K_RAND, 32'd0, 8'h07},
		'{K_RAND, 32'd0, 8'h08},
		'{K_RAND, 32'd0, 8'h09},
		'{K_END_HOLD, 32'd40, 8'h00},
		'{K_DRAIN, 32'd0, 8'h00},
		'{K_SAMPLE, 32'h00002000, 8'h0a},
		'{K_RAND, 32'd0, 8'h0b},
		'{K_COEF, 32'h00000000, 8'h00},
		'{K_COEF, 32'h00008000, 8'h01},
		'{K_COEF, 32'h00000000, 8'h02},
		'{K_COEF, 32'hffffeaab, 8'h03},
		'{K_SAMPLE, 32'h00002000, 8'h0c},
		'{K_RAND, 32'd0, 8'h0d},
		'{K_SAMPLE, 32'hffffc000, 8'h0e},
		'{K_DRAIN, 32'd0, 8'h00}
	};

	taylor_multicore u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_word    (in_word),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_tag    (out_tag),
		.out_core   (out_core),
		.out_credit (out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Horner's rule on the coefficients loaded so far.
	function automatic acc_t horner_model(input logic signed [18:0] x);
		logic signed [27:0] acc;
		logic signed [46:0] p;
		acc = 28'(coef_m[`ORDER-1]);
		for (int k = `ORDER - 2; k >= 0; k--) begin
			p   = 47'(acc) * 47'(x);
			acc = 28'(p >>> `FRAC_BITS) + 28'(coef_m[k]);
		end
		return acc;
	endfunction

	task automatic abort(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic take_result();
		if (!exp_live[out_tag]) begin
			abort($sformatf("Result with tag 0x%h was not expected", out_tag));
		end
		check_eq("out_data", out_data, exp_data[out_tag]);
		if (results == 0) begin
			check_eq("out_core", out_core, 0); // First sample lands on core 0.
		end
		exp_live[out_tag]   = 1'b0;
		core_mask[out_core] = 1'b1;
		outstanding--;
		results++;
		owed++;
		if (hold) begin
			hold_results++;
		end
	endtask

	// Samples the outputs at the falling edge and then drives the inputs.
	task automatic tick();
		@(negedge clk);
		avail       = avail + int'(credit_late);
		credit_late = in_credit; // Slot is free only after the pop edge.
		if (in_credit) begin
			credit_seen++;
		end
		if (sent == 0) begin
			check_eq("in_credit", in_credit, 0);
			check_eq("out_valid", out_valid, 0);
		end
		if (out_valid) begin
			take_result();
		end
		in_valid   = 1'b0;
		out_credit = 1'b0;
		if (!hold && owed > 0) begin
			if (ret_wait == 0) begin
				out_credit = 1'b1;
				owed--;
				rng      = xorshift(rng);
				ret_wait = int'(rng[1:0]);
			end else begin
				ret_wait--;
			end
		end
		if (arst_n) begin
			cycle++;
		end
	endtask

	task automatic send_word(input logic [31:0] word);
		int n;
		n = 0;
		tick();
		while (avail == 0) begin
			n++;
			if (n > TIMEOUT) begin
				abort("Timed out waiting for an input credit");
			end
			tick();
		end
		in_valid = 1'b1;
		in_word  = word;
		avail--;
		sent++;
	endtask

	task automatic issue_sample(input logic signed [18:0] x, input logic [7:0] tag);
		exp_data[tag] = horner_model(x);
		exp_live[tag] = 1'b1;
		outstanding++;
		send_word({1'b0, 4'b0, tag, x});
	endtask

	task automatic load_coef(input logic [1:0] idx, input logic signed [18:0] value);
		coef_m[idx] = value;
		send_word({1'b1, 10'b0, idx, value});
	endtask

	task automatic settle(input int until_cycle);
		int n;
		n = 0;
		while (cycle < until_cycle) begin
			n++;
			if (n > TIMEOUT) begin
				abort("Timed out waiting for the core releases");
			end
			tick();
		end
	endtask

	task automatic drain(input int min_cores);
		int n;
		n = 0;
		while (outstanding != 0 || owed != 0 || avail != `IN_CREDITS) begin
			n++;
			if (n > TIMEOUT) begin
				abort($sformatf("Timed out with %0d results still missing", outstanding));
			end
			tick();
		end
		if ($countones(core_mask) < min_cores) begin
			abort("Burst results came from fewer cores than expected");
		end
		core_mask = '0;
	endtask

	task automatic end_hold(input int window);
		for (int i = 0; i < window; i++) begin
			tick();
		end
		check_eq("results without credit return", hold_results, `OUT_CREDITS);
		hold = 1'b0;
	endtask

	initial begin
		arst_n       = 1'b0;
		in_valid     = 1'b0;
		in_word      = '0;
		out_credit   = 1'b0;
		rng          = 32'h18604fb8;
		exp_live     = '0;
		outstanding  = 0;
		sent         = 0;
		credit_seen  = 0;
		avail        = `IN_CREDITS;
		credit_late  = 1'b0;
		owed         = 0;
		ret_wait     = 0;
		hold         = 1'b0;
		cycle        = 0;
		results      = 0;
		hold_results = 0;
		core_mask    = '0;
		for (int k = 0; k < `ORDER; k++) begin
			coef_m[k] = '0;
		end
		repeat (5) tick();
		arst_n = 1'b1;
		for (int i = 0; i < N_STIM; i++) begin
			case (stim[i].kind)
				K_COEF: load_coef(stim[i].tag[1:0], stim[i].value[18:0]);
				K_SAMPLE: issue_sample(stim[i].value[18:0], stim[i].tag);
				K_RAND: begin
					rng = xorshift(rng);
					issue_sample({{3{rng[15]}}, rng[15:0]}, stim[i].tag); // Within +-1.0.
				end
				K_SETTLE: settle(int'(stim[i].value));
				K_HOLD: begin
					hold         = 1'b1;
					hold_results = 0;
				end
				K_END_HOLD: end_hold(int'(stim[i].value));
				K_DRAIN: drain(int'(stim[i].value));
				default: abort("Unknown kind of table entry");
			endcase
		end
		check_eq("in_credit pulse count", credit_seen, sent);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- taylor_multicore.f
+incdir+.
taylor_num_pkg.sv
taylor_bus_pkg.sv
taylor_core_if.sv
reset_stagger.sv
sample_dispatcher.sv
horner_core.sv
result_arbiter.sv
taylor_multicore.sv
tb_taylor_multicore.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f taylor_multicore.f \
	--top-module tb_taylor_multicore \
	-o sim_taylor_multicore

./obj_dir/sim_taylor_multicore
